//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing --assert
TOP      = uart_bridge_tb
FILELIST = uart_bridge.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- design/rx_fifo.sv
`timescale 1ns/100ps

module rx_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  uart_pkg::uart_byte_t push_data_i,
  input  logic                 push_i,
  input  logic                 rd_req_i,
  output logic                 rd_ack_o,
  output uart_pkg::uart_byte_t rd_data_o,
  output logic                 overrun_o
);
  import uart_pkg::*;

  localparam int ADDR_W = $clog2(FIFO_DEPTH);

  uart_byte_t        mem_q [FIFO_DEPTH];
  logic [ADDR_W:0]   wr_ptr_q;  // Extra bit tells full from empty.
  logic [ADDR_W:0]   rd_ptr_q;
  logic              empty;
  logic              full;
  logic              pop;
  logic              rd_ack_q;
  uart_byte_t        rd_data_q;
  logic              overrun_q;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                 (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

  // New request phase with data available.
  assign pop = rd_req_i && !rd_ack_q && !empty;

  // *************************************************************************
  // Push side
  // *************************************************************************

  always_ff @(posedge clk) begin
    if (push_i && !full) begin
      mem_q[wr_ptr_q[ADDR_W-1:0]] <= push_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q  <= '0;
      overrun_q <= 1'b0;
    end else if (push_i) begin
      if (full) begin
        overrun_q <= 1'b1;  // Byte lost, sticky.
      end else begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
    end
  end

  // *************************************************************************
  // Four-phase pop side
  // *************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr_q <= '0;
      rd_ack_q <= 1'b0;
    end else if (pop) begin
      rd_ptr_q <= rd_ptr_q + 1'b1;
      rd_ack_q <= 1'b1;
    end else if (rd_ack_q && !rd_req_i) begin
      rd_ack_q <= 1'b0;
    end
  end

  // Held through the acknowledge phase.
  always_ff @(posedge clk) begin
    if (pop) begin
      rd_data_q <= mem_q[rd_ptr_q[ADDR_W-1:0]];
    end
  end

  assign rd_ack_o  = rd_ack_q;
  assign rd_data_o = rd_data_q;
  assign overrun_o = overrun_q;

  ack_needs_req: assert property (@(posedge clk) disable iff (reset)
    (!rd_ack_o && !rd_req_i) |=> !rd_ack_o)
    else $error("rx_fifo: rd_ack_o rose without a read request");

endmodule

//--- design/uart_bridge.sv
`timescale 1ns/100ps

module uart_bridge #(
  parameter int CLOCK_RATE = 1_600_000,
  parameter int BAUD       = 100_000,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 serial_i,
  output logic                 serial_o,
  input  logic                 rd_req_i,
  output logic                 rd_ack_o,
  output uart_pkg::uart_byte_t rd_data_o,
  input  logic                 wr_req_i,
  input  uart_pkg::uart_byte_t wr_data_i,
  output logic                 wr_ack_o,
  output logic                 overrun_o
);
  import uart_pkg::*;

  uart_byte_t rx_data;
  logic       rx_strobe;

  // *************************************************************************
  // Receive path
  // *************************************************************************

  uart_rx #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD       (BAUD)
  ) u_rx (
    .clk         (clk),
    .reset       (reset),
    .serial_i    (serial_i),
    .rx_data_o   (rx_data),
    .rx_strobe_o (rx_strobe)
  );

  rx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk         (clk),
    .reset       (reset),
    .push_data_i (rx_data),
    .push_i      (rx_strobe),
    .rd_req_i    (rd_req_i),
    .rd_ack_o    (rd_ack_o),
    .rd_data_o   (rd_data_o),
    .overrun_o   (overrun_o)
  );

  // *************************************************************************
  // Transmit path
  // *************************************************************************

  uart_tx #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD       (BAUD)
  ) u_tx (
    .clk       (clk),
    .reset     (reset),
    .wr_req_i  (wr_req_i),
    .wr_data_i (wr_data_i),
    .wr_ack_o  (wr_ack_o),
    .serial_o  (serial_o)
  );

endmodule

//--- design/uart_pkg.sv
package uart_pkg;

  // *************************************************************************
  // Data widths
  // *************************************************************************

  // One byte on the line or at a host port.
  typedef logic [7:0] uart_byte_t;

  // Frame position, start bit 0 through stop bit 9.
  typedef logic [3:0] bit_index_t;

  // *************************************************************************
  // State encodings
  // *************************************************************************

  typedef enum logic [1:0] {
    rx_hunt,        // Waiting for a falling edge.
    rx_start_half,  // Start bit, up to its middle.
    rx_data,        // Eight data samples.
    rx_stop         // Up to the middle of the stop bit.
  } rx_state_t;

  typedef enum logic [1:0] {
    tx_idle,        // Line high, ready for a request.
    tx_send,        // Shifting one frame.
    tx_ack_wait     // Frame done, request still up.
  } tx_state_t;

endpackage

//--- design/uart_rx.sv
`timescale 1ns/100ps

module uart_rx #(
  parameter int CLOCK_RATE = 1_600_000,
  parameter int BAUD       = 100_000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 serial_i,
  output uart_pkg::uart_byte_t rx_data_o,
  output logic                 rx_strobe_o
);
  import uart_pkg::*;

  localparam int BIT_PERIOD  = CLOCK_RATE / BAUD;
  localparam int HALF_PERIOD = BIT_PERIOD / 2;
  localparam int CNT_W       = $clog2(BIT_PERIOD);

  logic             sync_meta_q;
  logic             sync_q;
  rx_state_t        state_q;
  logic [CNT_W-1:0] cnt_q;
  bit_index_t       idx_q;
  uart_byte_t       shift_q;
  logic             strobe_q;
  logic             cnt_done;
  logic             sample_en;

  // *************************************************************************
  // Line synchronizer
  // *************************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      sync_meta_q <= 1'b1;  // Idle level.
      sync_q      <= 1'b1;
    end else begin
      sync_meta_q <= serial_i;
      sync_q      <= sync_meta_q;
    end
  end

  // *************************************************************************
  // Frame FSM
  // *************************************************************************

  assign cnt_done  = (cnt_q == '0);
  assign sample_en = (state_q == rx_data) && cnt_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= rx_hunt;
      cnt_q    <= '0;
      idx_q    <= '0;
      strobe_q <= 1'b0;
    end else begin
      strobe_q <= 1'b0;
      case (state_q)
        rx_hunt: begin
          if (!sync_q) begin
            cnt_q   <= CNT_W'(HALF_PERIOD - 1);
            idx_q   <= '0;
            state_q <= rx_start_half;
          end
        end
        rx_start_half: begin
          if (!cnt_done) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (sync_q) begin
            state_q <= rx_hunt;  // Glitch, not a start bit.
          end else begin
            cnt_q   <= CNT_W'(BIT_PERIOD - 1);
            idx_q   <= 4'd1;
            state_q <= rx_data;
          end
        end
        rx_data: begin
          if (!cnt_done) begin
            cnt_q <= cnt_q - 1'b1;
          end else begin
            cnt_q <= CNT_W'(BIT_PERIOD - 1);
            idx_q <= idx_q + 1'b1;
            if (idx_q == 4'd8) begin
              strobe_q <= 1'b1;
              state_q  <= rx_stop;
            end
          end
        end
        rx_stop: begin
          // Stop bit is not checked; just wait out its first half.
          if (!cnt_done) begin
            cnt_q <= cnt_q - 1'b1;
          end else begin
            state_q <= rx_hunt;
          end
        end
        default: state_q <= rx_hunt;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top.
  always_ff @(posedge clk) begin
    if (sample_en) begin
      shift_q <= {sync_q, shift_q[7:1]};
    end
  end

  assign rx_data_o   = shift_q;
  assign rx_strobe_o = strobe_q;

  strobe_one_cycle: assert property (@(posedge clk) disable iff (reset)
    rx_strobe_o |=> !rx_strobe_o)
    else $error("uart_rx: byte strobe high on two consecutive cycles");

endmodule

//--- design/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
  parameter int CLOCK_RATE = 1_600_000,
  parameter int BAUD       = 100_000
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 wr_req_i,
  input  uart_pkg::uart_byte_t wr_data_i,
  output logic                 wr_ack_o,
  output logic                 serial_o
);
  import uart_pkg::*;

  localparam int BIT_PERIOD = CLOCK_RATE / BAUD;
  localparam int CNT_W      = $clog2(BIT_PERIOD);

  tx_state_t        state_q;
  logic [CNT_W-1:0] cnt_q;
  bit_index_t       idx_q;
  uart_byte_t       shift_q;
  logic             serial_q;
  logic             wr_ack_q;
  logic             accept;

  assign accept = (state_q == tx_idle) && wr_req_i && !wr_ack_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q  <= tx_idle;
      cnt_q    <= '0;
      idx_q    <= '0;
      serial_q <= 1'b1;
      wr_ack_q <= 1'b0;
    end else begin
      if (wr_ack_q && !wr_req_i) begin
        wr_ack_q <= 1'b0;  // Request gone, in any state.
      end
      case (state_q)
        tx_idle: begin
          if (accept) begin
            wr_ack_q <= 1'b1;
            serial_q <= 1'b0;  // Start bit.
            cnt_q    <= CNT_W'(BIT_PERIOD - 1);
            idx_q    <= '0;
            state_q  <= tx_send;
          end
        end
        tx_send: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
          end else if (idx_q == 4'd9) begin
            // End of stop bit; old handshake may still be open.
            if (wr_ack_q && wr_req_i) begin
              state_q <= tx_ack_wait;
            end else begin
              state_q <= tx_idle;
            end
          end else begin
            cnt_q    <= CNT_W'(BIT_PERIOD - 1);
            idx_q    <= idx_q + 1'b1;
            serial_q <= shift_q[0];  // All ones after data, i.e. stop.
          end
        end
        tx_ack_wait: begin
          if (!wr_req_i) begin
            state_q <= tx_idle;
          end
        end
        default: state_q <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      shift_q <= wr_data_i;
    end else if (state_q == tx_send && cnt_q == '0) begin
      shift_q <= {1'b1, shift_q[7:1]};
    end
  end

  assign wr_ack_o = wr_ack_q;
  assign serial_o = serial_q;

  idle_line_high: assert property (@(posedge clk) disable iff (reset)
    (state_q == tx_idle) |-> serial_o)
    else $error("uart_tx: line low while idle");

endmodule

//--- tests/uart_bridge_tb.sv
`timescale 1ns/100ps

module uart_bridge_tb;
  import uart_pkg::*;

  localparam int CLOCK_RATE  = 1_600_000;
  localparam int BAUD        = 100_000;
  localparam int FIFO_DEPTH  = 4;
  localparam int BIT_CYCLES  = CLOCK_RATE / BAUD;
  localparam int FRAMES      = 30 + 30 + 20 + 20 + FIFO_DEPTH + 2;
  localparam int WATCHDOG_NS = FRAMES * 10 * BIT_CYCLES * 10 * 3 + 2000;

  logic       clk;
  logic       reset;
  logic       serial_i;
  logic       serial_o;
  logic       rd_req_i;
  logic       rd_ack_o;
  uart_byte_t rd_data_o;
  logic       wr_req_i;
  uart_byte_t wr_data_i;
  logic       wr_ack_o;
  logic       overrun_o;

  int         errors = 0;
  uart_byte_t rx_exp[$];  // Bytes sent into serial_i.
  uart_byte_t tx_exp[$];  // Bytes written to the write port.
  logic       rd_ack_prev;
  logic       wr_ack_prev;
  uart_byte_t rd_data_prev;

  uart_bridge #(
    .CLOCK_RATE (CLOCK_RATE),
    .BAUD       (BAUD),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .clk       (clk),
    .reset     (reset),
    .serial_i  (serial_i),
    .serial_o  (serial_o),
    .rd_req_i  (rd_req_i),
    .rd_ack_o  (rd_ack_o),
    .rd_data_o (rd_data_o),
    .wr_req_i  (wr_req_i),
    .wr_data_i (wr_data_i),
    .wr_ack_o  (wr_ack_o),
    .overrun_o (overrun_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t before all tests finished", $time);
    $display("Test failed");
    $finish;
  end

  // *************************************************************************
  // Checks
  // *************************************************************************

  task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report_fault(input string msg);
    $display("%0t: %s", $time, msg);
    errors++;
  endtask

  // Four-phase rules on both host ports.
  always @(negedge clk) begin
    if (!reset) begin
      if (rd_ack_o && !rd_ack_prev && !rd_req_i) report_fault("rd_ack_o rose with no request");
      if (!rd_ack_o && rd_ack_prev && rd_req_i) report_fault("rd_ack_o fell before rd_req_i");
      if (rd_ack_o && rd_ack_prev && rd_data_o !== rd_data_prev)
        report_fault("rd_data_o changed while rd_ack_o was high");
      if (wr_ack_o && !wr_ack_prev && !wr_req_i) report_fault("wr_ack_o rose with no request");
      if (!wr_ack_o && wr_ack_prev && wr_req_i) report_fault("wr_ack_o fell before wr_req_i");
    end
    rd_ack_prev  = rd_ack_o;
    wr_ack_prev  = wr_ack_o;
    rd_data_prev = rd_data_o;
  end

  // Decodes frames on serial_o, sampled mid-bit.
  initial begin : serial_monitor
    uart_byte_t b;
    @(negedge reset);
    forever begin
      @(negedge serial_o);
      repeat (BIT_CYCLES / 2) @(negedge clk);
      if (serial_o) report_fault("start bit on serial_o was not low at its middle");
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYCLES) @(negedge clk);
        b[i] = serial_o;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      if (!serial_o) report_fault("stop bit on serial_o was low");
      if (tx_exp.size() == 0) report_fault("frame on serial_o with no byte written");
      else check_byte("serial_o", tx_exp.pop_front(), b);
    end
  end

  // *************************************************************************
  // Stimulus
  // *************************************************************************

  task automatic send_byte(input uart_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    rx_exp.push_back(b);
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      serial_i <= frame[i];
      repeat (BIT_CYCLES - 1) @(posedge clk);
    end
    repeat ($urandom_range(40)) @(posedge clk);  // Idle gap.
  endtask

  task automatic host_read(output uart_byte_t d);
    repeat ($urandom_range(5)) @(posedge clk);
    @(posedge clk);
    rd_req_i <= 1'b1;
    @(negedge clk);
    while (!rd_ack_o) @(negedge clk);
    d = rd_data_o;
    repeat ($urandom_range(5)) @(posedge clk);
    @(posedge clk);
    rd_req_i <= 1'b0;
    @(negedge clk);
    while (rd_ack_o) @(negedge clk);
  endtask

  task automatic host_write(input uart_byte_t b);
    repeat ($urandom_range(5)) @(posedge clk);
    @(posedge clk);
    wr_req_i  <= 1'b1;
    wr_data_i <= b;
    tx_exp.push_back(b);
    @(negedge clk);
    while (!wr_ack_o) @(negedge clk);
    repeat ($urandom_range(5)) @(posedge clk);
    @(posedge clk);
    wr_req_i <= 1'b0;
    @(negedge clk);
    while (wr_ack_o) @(negedge clk);
  endtask

  task automatic expect_no_ack(input int cycles);
    @(posedge clk);
    rd_req_i <= 1'b1;
    for (int i = 0; i < cycles && !rd_ack_o; i++) @(negedge clk);
    if (rd_ack_o) report_fault("read request acknowledged with an empty FIFO");
    @(posedge clk);
    rd_req_i <= 1'b0;
    @(negedge clk);
    while (rd_ack_o) @(negedge clk);
  endtask

  task automatic receive_bytes(input int n);
    uart_byte_t d;
    fork
      repeat (n) send_byte(uart_byte_t'($urandom));
      repeat (n) begin
        host_read(d);
        check_byte("rd_data_o", rx_exp.pop_front(), d);
      end
    join
  endtask

  task automatic transmit_bytes(input int n);
    repeat (n) host_write(uart_byte_t'($urandom));
    while (tx_exp.size() != 0) @(negedge clk);  // Last frame decoded.
  endtask

  initial begin
    uart_byte_t d;
    void'($urandom(32'hd69bea47));
    reset     = 1'b1;
    serial_i  = 1'b1;
    rd_req_i  = 1'b0;
    wr_req_i  = 1'b0;
    wr_data_i = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_flag("serial_o", 1'b1, serial_o);
    check_flag("overrun_o", 1'b0, overrun_o);
    expect_no_ack(50);

    receive_bytes(30);
    transmit_bytes(30);
    fork
      receive_bytes(20);
      transmit_bytes(20);
    join

    // Overrun runs last, the flag is sticky.
    repeat (FIFO_DEPTH) send_byte(uart_byte_t'($urandom));
    repeat (5) @(negedge clk);
    check_flag("overrun_o", 1'b0, overrun_o);
    repeat (2) send_byte(uart_byte_t'($urandom));
    repeat (5) @(negedge clk);
    check_flag("overrun_o", 1'b1, overrun_o);
    repeat (FIFO_DEPTH) begin
      host_read(d);
      check_byte("rd_data_o", rx_exp.pop_front(), d);
    end
    expect_no_ack(2 * 10 * BIT_CYCLES);
    check_flag("overrun_o", 1'b1, overrun_o);
    rx_exp.delete();

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- uart_bridge.f
design/uart_pkg.sv
design/uart_rx.sv
design/rx_fifo.sv
design/uart_tx.sv
design/uart_bridge.sv
tests/uart_bridge_tb.sv
